// ==== logic/packet_config.svh ====
`ifndef PACKET_CONFIG_SVH
`define PACKET_CONFIG_SVH

// Packet payload width in bits
`define PACKET_W 32

// Ring buffer address width, 16 entries
`define BUF_AW 4

// Edge PE lanes feeding the write arbiter
`define NUM_EDGE_PE 4

// Output FIFO address width, 4 entries
`define FIFO_AW 2

`endif

// ==== logic/packet_pkg.sv ====
`include "packet_config.svh"

package packet_pkg;

    // One packet as stored in the ring buffer
    typedef logic [`PACKET_W-1:0] packet_t;

    // Physical SRAM word address
    typedef logic [`BUF_AW-1:0] sram_addr_t;

    // Ring pointer, MSB is the wrap bit
    typedef logic [`BUF_AW:0] buf_ptr_t;

    // Read sequencer states
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_STREAM,
        SEQ_HALT
    } seq_state_t;

endpackage

// ==== logic/write_arbiter.sv ====
`timescale 1ns/1ps
`include "packet_config.svh"

module write_arbiter (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          replay,
    input  logic                          accept_en,
    input  logic                          dp_valid,
    input  packet_pkg::packet_t           dp_packet,
    output logic                          dp_ready,
    input  logic [`NUM_EDGE_PE-1:0]       pe_valid,
    input  packet_pkg::packet_t           pe_packet [`NUM_EDGE_PE],
    output logic [`NUM_EDGE_PE-1:0]       pe_ready,
    output logic                          wr_req,
    output packet_pkg::sram_addr_t        wr_addr,
    output packet_pkg::packet_t           wr_data,
    output packet_pkg::buf_ptr_t          wr_ptr
);
    import packet_pkg::*;

    logic    grant_en;
    logic    lower_valid;
    packet_t pe_data;

    // A write in the replay cycle would be lost when the pointer clears
    assign grant_en = accept_en && !replay;

    // Each PE ready only looks at the datapath and the lower lanes,
    // never at its own valid
    always_comb begin
        pe_ready    = '0;
        pe_data     = pe_packet[0];
        lower_valid = 1'b0;
        for (int i = 0; i < `NUM_EDGE_PE; i++) begin
            pe_ready[i] = grant_en && !dp_valid && !lower_valid;
            if (pe_valid[i] && !lower_valid) begin
                pe_data = pe_packet[i];
            end
            lower_valid = lower_valid | pe_valid[i];
        end
    end

    assign dp_ready = grant_en;
    assign wr_req   = grant_en && (dp_valid || (|pe_valid));
    assign wr_data  = dp_valid ? dp_packet : pe_data;
    assign wr_addr  = wr_ptr[`BUF_AW-1:0];

    always_ff @(posedge clk) begin
        if (reset || replay) begin
            wr_ptr <= '0;
        end else if (wr_req) begin
            wr_ptr <= wr_ptr + buf_ptr_t'(1);
        end
    end

endmodule

// ==== logic/read_sequencer.sv ====
`timescale 1ns/1ps
`include "packet_config.svh"

module read_sequencer (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   replay,
    input  logic                   done,
    input  packet_pkg::buf_ptr_t   wr_ptr,
    input  logic                   wr_req,
    input  logic                   fifo_space,
    output logic                   accept_en,
    output logic                   rd_req,
    output packet_pkg::sram_addr_t rd_addr
);
    import packet_pkg::*;

    seq_state_t state;
    seq_state_t state_next;
    buf_ptr_t   rd_ptr;
    buf_ptr_t   occupancy;
    logic       buf_full;
    logic       buf_non_empty;
    logic       streaming;

    // Wrap bit makes the difference the exact fill level
    assign occupancy     = wr_ptr - rd_ptr;
    assign buf_full      = occupancy[`BUF_AW];
    assign buf_non_empty = (occupancy != '0);
    assign streaming     = (state == SEQ_STREAM);

    always_comb begin
        state_next = state;
        case (state)
            SEQ_IDLE: begin
                state_next = SEQ_STREAM;
            end
            SEQ_STREAM: begin
                if (done) begin
                    state_next = SEQ_HALT;
                end
            end
            // Held until replay or reset
            SEQ_HALT: begin
                state_next = SEQ_HALT;
            end
            default: begin
                state_next = SEQ_IDLE;
            end
        endcase
    end

    // Replay takes priority over a done in the same cycle
    always_ff @(posedge clk) begin
        if (reset || replay) begin
            state  <= SEQ_IDLE;
            rd_ptr <= '0;
        end else begin
            state <= state_next;
            if (rd_req) begin
                rd_ptr <= rd_ptr + buf_ptr_t'(1);
            end
        end
    end

    assign accept_en = streaming && !buf_full;

    // Reads only fill port cycles left free by the writer
    assign rd_req  = streaming && !wr_req && buf_non_empty && fifo_space;
    assign rd_addr = rd_ptr[`BUF_AW-1:0];

endmodule

// ==== logic/sram_port_ctrl.sv ====
`timescale 1ns/1ps
`include "packet_config.svh"

module sram_port_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   replay,
    input  logic                   wr_req,
    input  packet_pkg::sram_addr_t wr_addr,
    input  packet_pkg::packet_t    wr_data,
    input  logic                   rd_req,
    input  packet_pkg::sram_addr_t rd_addr,
    output logic                   sram_en,
    output logic                   sram_we,
    output packet_pkg::sram_addr_t sram_addr,
    output packet_pkg::packet_t    sram_wdata,
    input  packet_pkg::packet_t    sram_rdata,
    input  logic [`FIFO_AW:0]      fifo_count,
    output logic                   fifo_push,
    output packet_pkg::packet_t    fifo_data,
    output logic                   fifo_space
);
    localparam logic [`FIFO_AW+1:0] FIFO_DEPTH = (`FIFO_AW+2)'(1 << `FIFO_AW);

    logic                 rd_pending;
    logic [`FIFO_AW+1:0]  credit_used;

    // Write owns the port whenever it asks
    assign sram_en    = wr_req || rd_req;
    assign sram_we    = wr_req;
    assign sram_addr  = wr_req ? wr_addr : rd_addr;
    assign sram_wdata = wr_data;

    // One read in flight while the SRAM output register fills
    always_ff @(posedge clk) begin
        if (reset || replay) begin
            rd_pending <= 1'b0;
        end else begin
            rd_pending <= rd_req;
        end
    end

    assign fifo_push = rd_pending;
    assign fifo_data = sram_rdata;

    // Reserve a slot for the read still on its way
    assign credit_used = {1'b0, fifo_count} + {{(`FIFO_AW+1){1'b0}}, rd_pending};
    assign fifo_space  = (credit_used < FIFO_DEPTH);

endmodule

// ==== logic/packet_sram.sv ====
`timescale 1ns/1ps
`include "packet_config.svh"

module packet_sram (
    input  logic                   clk,
    input  logic                   en,
    input  logic                   we,
    input  packet_pkg::sram_addr_t addr,
    input  packet_pkg::packet_t    wdata,
    output packet_pkg::packet_t    rdata
);
    import packet_pkg::*;

    localparam int DEPTH = 1 << `BUF_AW;

    packet_t mem [DEPTH];

    // Single port, read data valid the cycle after the request
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

// ==== logic/packet_fifo.sv ====
`timescale 1ns/1ps
`include "packet_config.svh"

module packet_fifo (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  logic                push,
    input  packet_pkg::packet_t push_data,
    output logic [`FIFO_AW:0]   count,
    output logic                out_valid,
    output packet_pkg::packet_t out_packet,
    input  logic                out_ready
);
    import packet_pkg::*;

    localparam int DEPTH = 1 << `FIFO_AW;

    packet_t              mem [DEPTH];
    logic [`FIFO_AW-1:0]  wr_idx;
    logic [`FIFO_AW-1:0]  rd_idx;
    logic                 fifo_full;
    logic                 push_ok;
    logic                 pop;

    assign fifo_full  = count[`FIFO_AW];
    assign out_valid  = (count != '0);
    assign out_packet = mem[rd_idx];
    assign pop        = out_valid && out_ready;

    // Upstream credit keeps this from ever dropping data
    assign push_ok = push && !fifo_full;

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_idx] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wr_idx <= '0;
            rd_idx <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_idx <= wr_idx + 1'b1;
            end
            if (pop) begin
                rd_idx <= rd_idx + 1'b1;
            end
            case ({push_ok, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== logic/packet_buffer.sv ====
`timescale 1ns/1ps
`include "packet_config.svh"

module packet_buffer (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    replay,
    input  logic                    done,
    input  logic                    dp_valid,
    input  packet_pkg::packet_t     dp_packet,
    output logic                    dp_ready,
    input  logic [`NUM_EDGE_PE-1:0] pe_valid,
    input  packet_pkg::packet_t     pe_packet [`NUM_EDGE_PE],
    output logic [`NUM_EDGE_PE-1:0] pe_ready,
    output logic                    out_valid,
    output packet_pkg::packet_t     out_packet,
    input  logic                    out_ready
);
    import packet_pkg::*;

    logic                accept_en;
    logic                wr_req;
    sram_addr_t          wr_addr;
    packet_t             wr_data;
    buf_ptr_t            wr_ptr;
    logic                rd_req;
    sram_addr_t          rd_addr;
    logic                sram_en;
    logic                sram_we;
    sram_addr_t          sram_addr;
    packet_t             sram_wdata;
    packet_t             sram_rdata;
    logic [`FIFO_AW:0]   fifo_count;
    logic                fifo_push;
    packet_t             fifo_data;
    logic                fifo_space;

    write_arbiter u_write_arbiter (
        .clk       (clk),
        .reset     (reset),
        .replay    (replay),
        .accept_en (accept_en),
        .dp_valid  (dp_valid),
        .dp_packet (dp_packet),
        .dp_ready  (dp_ready),
        .pe_valid  (pe_valid),
        .pe_packet (pe_packet),
        .pe_ready  (pe_ready),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_ptr    (wr_ptr)
    );

    read_sequencer u_read_sequencer (
        .clk        (clk),
        .reset      (reset),
        .replay     (replay),
        .done       (done),
        .wr_ptr     (wr_ptr),
        .wr_req     (wr_req),
        .fifo_space (fifo_space),
        .accept_en  (accept_en),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr)
    );

    sram_port_ctrl u_sram_port_ctrl (
        .clk        (clk),
        .reset      (reset),
        .replay     (replay),
        .wr_req     (wr_req),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .sram_en    (sram_en),
        .sram_we    (sram_we),
        .sram_addr  (sram_addr),
        .sram_wdata (sram_wdata),
        .sram_rdata (sram_rdata),
        .fifo_count (fifo_count),
        .fifo_push  (fifo_push),
        .fifo_data  (fifo_data),
        .fifo_space (fifo_space)
    );

    packet_sram u_packet_sram (
        .clk   (clk),
        .en    (sram_en),
        .we    (sram_we),
        .addr  (sram_addr),
        .wdata (sram_wdata),
        .rdata (sram_rdata)
    );

    // Replay also discards whatever is waiting at the output
    packet_fifo u_packet_fifo (
        .clk        (clk),
        .reset      (reset),
        .flush      (replay),
        .push       (fifo_push),
        .push_data  (fifo_data),
        .count      (fifo_count),
        .out_valid  (out_valid),
        .out_packet (out_packet),
        .out_ready  (out_ready)
    );

endmodule

// ==== test/packet_checker.sv ====
`timescale 1ns/1ps
`include "packet_config.svh"

module packet_checker (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    replay,
    input  logic                    done,
    input  logic                    dp_valid,
    input  packet_pkg::packet_t     dp_packet,
    input  logic                    dp_ready,
    input  logic [`NUM_EDGE_PE-1:0] pe_valid,
    input  packet_pkg::packet_t     pe_packet [`NUM_EDGE_PE],
    input  logic [`NUM_EDGE_PE-1:0] pe_ready,
    input  logic                    out_valid,
    input  packet_pkg::packet_t     out_packet,
    input  logic                    out_ready,
    output int                      error_count,
    output int                      pending_count
);
    import packet_pkg::*;

    // Ring buffer plus output FIFO plus one packet in the write cycle
    localparam int MAX_HELD       = (1 << `BUF_AW) + (1 << `FIFO_AW) + 1;
    localparam int MAX_AFTER_DONE = 1 << `FIFO_AW;

    packet_t model_q [$];
    int      errors     = 0;
    int      after_done = 0;
    logic    halted     = 1'b0;
    logic    reset_d    = 1'b0;

    always @(posedge clk) begin
        int      n_hs;
        int      hs_id;
        int      winner;
        packet_t got;
        packet_t want;
        n_hs   = 0;
        hs_id  = -2;
        winner = -2;
        got    = '0;
        if (reset) begin
            if (reset_d && (out_valid || dp_ready || pe_ready != '0)) begin
                $display("FAIL at %0t: ready or out_valid high during reset", $time);
                errors++;
            end
            model_q.delete();
            halted     = 1'b0;
            after_done = 0;
        end else begin
            if (out_valid && out_ready) begin
                if (halted) begin
                    after_done++;
                end
                if (model_q.size() == 0) begin
                    $display("FAIL at %0t: output %h with no packet accepted", $time, out_packet);
                    errors++;
                end else begin
                    want = model_q.pop_front();
                    if (out_packet !== want) begin
                        $display("FAIL at %0t: output %h, expected %h", $time, out_packet, want);
                        errors++;
                    end
                end
            end
            if (after_done == MAX_AFTER_DONE + 1) begin
                $display("FAIL at %0t: more than %0d outputs after done", $time, MAX_AFTER_DONE);
                errors++;
            end
            // Expected winner: datapath first, then lowest-index PE
            if (dp_valid) begin
                winner = -1;
            end else begin
                for (int i = `NUM_EDGE_PE - 1; i >= 0; i--) begin
                    if (pe_valid[i]) begin
                        winner = i;
                    end
                end
            end
            if (dp_valid && dp_ready) begin
                n_hs++;
                hs_id = -1;
                got   = dp_packet;
            end
            for (int i = 0; i < `NUM_EDGE_PE; i++) begin
                if (pe_valid[i] && pe_ready[i]) begin
                    n_hs++;
                    hs_id = i;
                    got   = pe_packet[i];
                end
            end
            if (n_hs > 1) begin
                $display("FAIL at %0t: %0d senders accepted in one cycle", $time, n_hs);
                errors++;
            end else if (n_hs == 1) begin
                if (hs_id != winner) begin
                    $display("FAIL at %0t: sender %0d accepted, expected %0d", $time, hs_id, winner);
                    errors++;
                end
                if (halted) begin
                    $display("FAIL at %0t: packet accepted after done", $time);
                    errors++;
                end
                model_q.push_back(got);
            end
            if (model_q.size() > MAX_HELD) begin
                $display("FAIL at %0t: %0d packets held, limit %0d", $time, model_q.size(), MAX_HELD);
                errors++;
            end
            // Replay wins over done in the same cycle
            if (replay) begin
                model_q.delete();
                halted     = 1'b0;
                after_done = 0;
            end else if (done) begin
                halted = 1'b1;
            end
        end
        reset_d = reset;
        error_count   <= errors;
        pending_count <= model_q.size();
    end

endmodule

// ==== test/tb_packet_buffer.sv ====
`timescale 1ns/1ps
`include "packet_config.svh"

module tb_packet_buffer;
    import packet_pkg::*;

    localparam int TIMEOUT = 2000;

    logic                    clk = 1'b0;
    logic                    reset;
    logic                    replay;
    logic                    done;
    logic                    dp_valid;
    packet_t                 dp_packet;
    logic                    dp_ready;
    logic [`NUM_EDGE_PE-1:0] pe_valid;
    packet_t                 pe_packet [`NUM_EDGE_PE];
    logic [`NUM_EDGE_PE-1:0] pe_ready;
    logic                    out_valid;
    packet_t                 out_packet;
    logic                    out_ready;
    int                      error_count;
    int                      pending_count;
    integer                  seed = 32'h91c2;
    int                      tests_run = 0;
    int                      tests_failed = 0;
    int                      errs_start;
    int                      n;
    bit                      timed_out;

    always #5 clk = ~clk;

    packet_buffer UUT (
        .clk        (clk),
        .reset      (reset),
        .replay     (replay),
        .done       (done),
        .dp_valid   (dp_valid),
        .dp_packet  (dp_packet),
        .dp_ready   (dp_ready),
        .pe_valid   (pe_valid),
        .pe_packet  (pe_packet),
        .pe_ready   (pe_ready),
        .out_valid  (out_valid),
        .out_packet (out_packet),
        .out_ready  (out_ready)
    );

    packet_checker u_checker (
        .clk           (clk),
        .reset         (reset),
        .replay        (replay),
        .done          (done),
        .dp_valid      (dp_valid),
        .dp_packet     (dp_packet),
        .dp_ready      (dp_ready),
        .pe_valid      (pe_valid),
        .pe_packet     (pe_packet),
        .pe_ready      (pe_ready),
        .out_valid     (out_valid),
        .out_packet    (out_packet),
        .out_ready     (out_ready),
        .error_count   (error_count),
        .pending_count (pending_count)
    );

    function automatic logic chance(input int pct);
        return ($unsigned($random(seed)) % 100) < pct;
    endfunction

    // One clock of stimulus
    // Each sender holds its packet until accepted
    task automatic step(input int dp_pct, input int pe_pct, input int rdy_pct);
        @(posedge clk);
        if (!dp_valid || dp_ready) begin
            dp_valid  <= chance(dp_pct);
            dp_packet <= $random(seed);
        end
        for (int i = 0; i < `NUM_EDGE_PE; i++) begin
            if (!pe_valid[i] || pe_ready[i]) begin
                pe_valid[i]  <= chance(pe_pct);
                pe_packet[i] <= $random(seed);
            end
        end
        out_ready <= chance(rdy_pct);
        done      <= 1'b0;
        replay    <= 1'b0;
    endtask

    function automatic logic busy();
        return dp_valid || (pe_valid != '0) || (pending_count != 0);
    endfunction

    // Stop offering new packets and wait until everything has come out
    task automatic drain();
        n = 0;
        while (busy() && n < TIMEOUT) begin
            step(0, 0, 100);
            n++;
        end
        if (busy()) begin
            $display("Timeout: packets still pending after %0d cycles", TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    task automatic start_test();
        @(negedge clk);
        errs_start = error_count;
        timed_out  = 1'b0;
    endtask

    task automatic finish_test(input string name);
        @(negedge clk);
        tests_run++;
        if (error_count != errs_start || timed_out) begin
            tests_failed++;
            $display("Test %0d %s: failed", tests_run, name);
        end else begin
            $display("Test %0d %s: passed", tests_run, name);
        end
    endtask

    initial begin
        reset     = 1'b1;
        replay    = 1'b0;
        done      = 1'b0;
        dp_valid  = 1'b0;
        dp_packet = '0;
        pe_valid  = '0;
        for (int i = 0; i < `NUM_EDGE_PE; i++) begin
            pe_packet[i] = '0;
        end
        out_ready = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        start_test();
        repeat (10) step(0, 0, 100);
        repeat (60) step(60, 0, 100);
        drain();
        finish_test("reset and datapath stream");

        start_test();
        repeat (100) step(50, 50, 100);
        drain();
        finish_test("arbitration priority");

        start_test();
        n = 0;
        while (dp_ready && n < TIMEOUT) begin
            step(80, 50, 0);
            n++;
        end
        if (dp_ready) begin
            $display("Timeout: ready still high after %0d cycles of back-pressure", TIMEOUT);
            timed_out = 1'b1;
        end
        repeat (20) step(80, 50, 0);
        drain();
        finish_test("back-pressure");

        start_test();
        repeat (200) step(50, 40, 50);
        drain();
        finish_test("random out_ready");

        start_test();
        repeat (30) step(70, 30, 0);
        step(70, 30, 0);
        done <= 1'b1;
        n = 0;
        while (out_valid && n < TIMEOUT) begin
            step(0, 0, 100);
            n++;
        end
        if (out_valid) begin
            $display("Timeout: output not empty %0d cycles after done", TIMEOUT);
            timed_out = 1'b1;
        end
        repeat (10) step(0, 0, 100);
        finish_test("done halts traffic");

        start_test();
        step(0, 0, 100);
        replay <= 1'b1;
        // Fill the output FIFO, then free one slot so a read is in flight at replay
        repeat (40) step(70, 30, 0);
        step(70, 30, 100);
        step(70, 30, 0);
        replay <= 1'b1;
        repeat (100) step(50, 40, 70);
        drain();
        finish_test("replay restart");

        $display("Tests run: %0d, failed: %0d, checker errors: %0d",
                 tests_run, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== packet_buffer.f ====
+incdir+logic
logic/packet_pkg.sv
logic/write_arbiter.sv
logic/read_sequencer.sv
logic/sram_port_ctrl.sv
logic/packet_sram.sv
logic/packet_fifo.sv
logic/packet_buffer.sv
test/packet_checker.sv
test/tb_packet_buffer.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the packet buffer testbench with Verilator, result taken from sim.log

verilator --binary --top-module tb_packet_buffer -f packet_buffer.f -o sim_packet_buffer \
    && ./obj_dir/sim_packet_buffer > sim.log 2>&1 \
    || { echo "Build or simulation run did not complete, see sim.log"; exit 1; }

grep -q "Test failures found" sim.log \
    && { echo "Simulation FAILED, see sim.log"; exit 1; } \
    || { echo "Simulation PASSED"; exit 0; }
